//--- source/lmmi_pkg.sv
/*
	Shared constants for the LMMI bridge subsystem
	Local bus is a 4-bit register address with 32-bit data words
	Register indices and bit positions are the host software view
	and must not change without updating the host driver
*/

`default_nettype none

package lmmi_pkg;

	// Local bus address width
	localparam int LB_ADR_W = 4;

	// Local bus data width
	localparam int LB_DAT_W = 32;

	// Register map
	// Control, start bits self-clear
	localparam int REG_CTL = 0;

	// Status, busy and read-data-ready
	localparam int REG_STA = 1;

	// Selector word on write, captured read data on read
	localparam int REG_LMMI = 2;

	// Control register bits
	// Start an LMMI write
	localparam int CTL_WR = 0;

	// Start an LMMI read
	localparam int CTL_RD = 1;

	localparam int CTL_W = 2;

	// Status register bits
	// Transaction in flight, cleared by the target ready
	localparam int STA_BUSY = 0;

	// Read data captured, host clears by writing 1
	localparam int STA_RDY = 1;

	localparam int STA_W = 2;

endpackage

`default_nettype wire

//--- source/lmmi_target.sv
/*
	LMMI register bank target, stands in for a hard block config port
	Answers a held request after P_WAIT cycles with a one-cycle ready
	Read data follows with a one-cycle valid, one cycle after ready
	Bank has no reset, contents are defined only after a write
*/

`default_nettype none

module lmmi_target
#(
	parameter int P_ADR = 9,
	parameter int P_DAT = 8,
	parameter int P_WAIT = 0
)
(
	input wire CLK_IN,
	input wire RST_IN,

	// LMMI from the bridge
	input wire req,
	input wire dir,
	input wire [P_ADR-1:0] adr,
	input wire [P_DAT-1:0] wdat,

	// LMMI to the bridge
	output logic [P_DAT-1:0] rdat,
	output logic vld,
	output logic rdy
);

// Counter needs one bit even with no wait states
localparam int CNT_W = (P_WAIT > 0) ? $clog2(P_WAIT + 1) : 1;
localparam int DEPTH = 2 ** P_ADR;

// Register bank
logic [P_DAT-1:0] bank [DEPTH];

// Wait counter and handshake state
logic [CNT_W-1:0] cnt;
logic done;
logic accept;
logic rd_acc;

// Accept once the wait count is reached
// Done blocks the tail of the same request
assign accept = req && !done && (cnt == CNT_W'(P_WAIT));

// Handshake control
always_ff @(posedge CLK_IN, posedge RST_IN)
begin
	if (RST_IN)
	begin
		cnt <= '0;
		done <= 1'b0;
		rd_acc <= 1'b0;
		rdy <= 1'b0;
		vld <= 1'b0;
	end
	else
	begin
		// One-cycle ready on acceptance
		rdy <= accept;

		// Valid one cycle after a read was accepted
		vld <= rdy && rd_acc;

		// Request gone, rearm
		if (!req)
		begin
			cnt <= '0;
			done <= 1'b0;
		end
		else if (accept)
		begin
			done <= 1'b1;
			rd_acc <= !dir;
		end
		// Back-pressure phase
		else if (!done)
			cnt <= cnt + 1'b1;
	end
end

// Bank access at acceptance
// Read data stays on rdat until the next read
always_ff @(posedge CLK_IN)
begin
	if (accept)
	begin
		if (dir)
			bank[adr] <= wdat;
		else
			rdat <= bank[adr];
	end
end

// Ready only inside a request
a_rdy_req: assert property (@(posedge CLK_IN) disable iff (RST_IN)
	rdy |-> req)
	else $error("LMMI rdy without req");

// Valid only after a read acceptance
a_vld_rd: assert property (@(posedge CLK_IN) disable iff (RST_IN)
	vld |-> $past(rdy && !dir))
	else $error("LMMI vld without a preceding read rdy");

// Bridge must hold the request steady under back-pressure
a_req_hold: assert property (@(posedge CLK_IN) disable iff (RST_IN)
	(req && !done) |=> (req && $stable(dir) && $stable(adr) && $stable(wdat)))
	else $error("LMMI request changed while waiting");

endmodule

`default_nettype wire

//--- source/lmmi_bridge.sv
/*
	Local-bus to LMMI bridge, one outstanding transaction at a time
	Host writes the selector word (port, address, data) and then a start bit
	Selector and port must not change while busy is set
	Host must wait for the lb_vld response cycle before the next strobe
	Selector word must fit in the 32-bit local-bus data word
*/

`default_nettype none

module lmmi_bridge
#(
	parameter int P_PORTS = 4,
	parameter int P_ADR = 9,
	parameter int P_DAT = 8
)
(
	input wire CLK_IN,
	input wire RST_IN,

	// Local bus
	input wire [lmmi_pkg::LB_ADR_W-1:0] lb_adr,
	input wire lb_wr,
	input wire lb_rd,
	input wire [lmmi_pkg::LB_DAT_W-1:0] lb_din,
	output logic [lmmi_pkg::LB_DAT_W-1:0] lb_dout,
	output logic lb_vld,

	// LMMI, one slice per port
	output logic [P_PORTS-1:0] lmmi_req,
	output logic [P_PORTS-1:0] lmmi_dir,
	output logic [P_PORTS*P_ADR-1:0] lmmi_adr,
	output logic [P_PORTS*P_DAT-1:0] lmmi_wdat,
	input wire [P_PORTS*P_DAT-1:0] lmmi_rdat,
	input wire [P_PORTS-1:0] lmmi_vld,
	input wire [P_PORTS-1:0] lmmi_rdy
);

// Selector word layout
localparam int PORT_W = $clog2(P_PORTS);
localparam int SEL_ADR_LSB = PORT_W;
localparam int SEL_DAT_LSB = PORT_W + P_ADR;

// Registered local bus
logic [lmmi_pkg::LB_ADR_W-1:0] lb_adr_r;
logic lb_wr_r;
logic lb_rd_r;
logic [lmmi_pkg::LB_DAT_W-1:0] lb_din_r;

// Address decode
logic ctl_sel;
logic sta_sel;
logic wr_ctl;
logic wr_sta;
logic wr_sel;

// Control and status
logic [lmmi_pkg::CTL_W-1:0] ctl_r;
logic [lmmi_pkg::STA_W-1:0] sta_r;
logic start;
logic busy;
logic rd_rdy;

// Selector fields
logic [PORT_W-1:0] port_sel;
logic [P_ADR-1:0] adr_sel;
logic [P_DAT-1:0] wdat_sel;

// Valid edge detection and read capture
logic [P_PORTS-1:0] vld_prev;
logic [P_PORTS-1:0] vld_re;
logic [P_DAT-1:0] rd_data;

// Elaboration checks on the parameter set
if (P_PORTS < 2)
begin : g_port_chk
	$error("lmmi_bridge needs at least two ports");
end

if (SEL_DAT_LSB + P_DAT > lmmi_pkg::LB_DAT_W)
begin : g_sel_chk
	$error("Selector word does not fit in the local-bus data word");
end

// Local bus strobes
always_ff @(posedge CLK_IN, posedge RST_IN)
begin
	if (RST_IN)
	begin
		lb_wr_r <= 1'b0;
		lb_rd_r <= 1'b0;
	end
	else
	begin
		lb_wr_r <= lb_wr;
		lb_rd_r <= lb_rd;
	end
end

// Local bus address and data, sampled every cycle
always_ff @(posedge CLK_IN)
begin
	lb_adr_r <= lb_adr;
	lb_din_r <= lb_din;
end

// Decode of the registered address
assign ctl_sel = (lb_adr_r == lmmi_pkg::REG_CTL);
assign sta_sel = (lb_adr_r == lmmi_pkg::REG_STA);
assign wr_ctl = ctl_sel && lb_wr_r;
assign wr_sta = sta_sel && lb_wr_r;
assign wr_sel = (lb_adr_r == lmmi_pkg::REG_LMMI) && lb_wr_r;

// Read mux
// Any other address returns the last captured LMMI byte
always_comb
begin
	lb_dout = '0;
	if (ctl_sel)
		lb_dout[lmmi_pkg::CTL_W-1:0] = ctl_r;
	else if (sta_sel)
		lb_dout[lmmi_pkg::STA_W-1:0] = sta_r;
	else
		lb_dout[P_DAT-1:0] = rd_data;
end

// Response in the cycle after the strobe
assign lb_vld = lb_rd_r;

// Control register
// Start bits live for one cycle only
always_ff @(posedge CLK_IN, posedge RST_IN)
begin
	if (RST_IN)
		ctl_r <= '0;
	else if (wr_ctl)
		ctl_r <= lb_din_r[lmmi_pkg::CTL_W-1:0];
	else
		ctl_r <= '0;
end

assign start = |ctl_r;

// Busy
// Set together with the start bit, so it covers the whole request
always_ff @(posedge CLK_IN, posedge RST_IN)
begin
	if (RST_IN)
		busy <= 1'b0;
	else if (wr_ctl && (|lb_din_r[lmmi_pkg::CTL_W-1:0]))
		busy <= 1'b1;
	else if (|lmmi_rdy)
		busy <= 1'b0;
end

// Read data ready
// Host clear wins over a coincident valid edge
always_ff @(posedge CLK_IN, posedge RST_IN)
begin
	if (RST_IN)
		rd_rdy <= 1'b0;
	else if (wr_sta && lb_din_r[lmmi_pkg::STA_RDY])
		rd_rdy <= 1'b0;
	else if (|vld_re)
		rd_rdy <= 1'b1;
end

assign sta_r[lmmi_pkg::STA_BUSY] = busy;
assign sta_r[lmmi_pkg::STA_RDY] = rd_rdy;

// Port field steers req and dir
always_ff @(posedge CLK_IN, posedge RST_IN)
begin
	if (RST_IN)
		port_sel <= '0;
	else if (wr_sel)
		port_sel <= lb_din_r[PORT_W-1:0];
end

// Address and write data fields
always_ff @(posedge CLK_IN)
begin
	if (wr_sel)
	begin
		adr_sel <= lb_din_r[SEL_ADR_LSB +: P_ADR];
		wdat_sel <= lb_din_r[SEL_DAT_LSB +: P_DAT];
	end
end

// Broadcast to every port, only req qualifies them
assign lmmi_adr = {P_PORTS{adr_sel}};
assign lmmi_wdat = {P_PORTS{wdat_sel}};

// Previous valid per port
always_ff @(posedge CLK_IN, posedge RST_IN)
begin
	if (RST_IN)
		vld_prev <= '0;
	else
		vld_prev <= lmmi_vld;
end

assign vld_re = lmmi_vld & ~vld_prev;

// Capture read byte on the valid edge
always_ff @(posedge CLK_IN, posedge RST_IN)
begin
	if (RST_IN)
		rd_data <= '0;
	else
	begin
		for (int i = 0; i < P_PORTS; i++)
		begin
			if (vld_re[i])
				rd_data <= lmmi_rdat[i*P_DAT +: P_DAT];
		end
	end
end

// Request and direction
// Raised on the start bit, held until the target ready
// Unselected ports are forced idle
always_ff @(posedge CLK_IN, posedge RST_IN)
begin
	if (RST_IN)
	begin
		lmmi_req <= '0;
		lmmi_dir <= '0;
	end
	else
	begin
		for (int i = 0; i < P_PORTS; i++)
		begin
			if ((port_sel == PORT_W'(i)) && start)
			begin
				lmmi_req[i] <= 1'b1;
				lmmi_dir[i] <= ctl_r[lmmi_pkg::CTL_WR];
			end
			else if ((port_sel != PORT_W'(i)) || lmmi_rdy[i])
			begin
				lmmi_req[i] <= 1'b0;
				lmmi_dir[i] <= 1'b0;
			end
		end
	end
end

// Single outstanding transaction across all ports
a_req_onehot: assert property (@(posedge CLK_IN) disable iff (RST_IN)
	$onehot0(lmmi_req))
	else $error("More than one LMMI request active");

// Direction only qualifies a live request
a_dir_req: assert property (@(posedge CLK_IN) disable iff (RST_IN)
	((lmmi_dir & ~lmmi_req) == '0))
	else $error("LMMI dir high without req");

// Status must show every request in flight
a_busy_req: assert property (@(posedge CLK_IN) disable iff (RST_IN)
	(|lmmi_req) |-> busy)
	else $error("LMMI request active while busy is clear");

endmodule

`default_nettype wire

//--- source/lmmi_subsys.sv
/*
	LMMI bridge subsystem, the bridge plus one register-bank target per port
	Only the local bus leaves this level
	Wait states per port come from a fixed lookup, repeated past port 3
*/

`default_nettype none

module lmmi_subsys
#(
	parameter int P_PORTS = 4,
	parameter int P_ADR = 9,
	parameter int P_DAT = 8
)
(
	input wire CLK_IN,
	input wire RST_IN,

	// Local bus
	input wire [lmmi_pkg::LB_ADR_W-1:0] lb_adr,
	input wire lb_wr,
	input wire lb_rd,
	input wire [lmmi_pkg::LB_DAT_W-1:0] lb_din,
	output logic [lmmi_pkg::LB_DAT_W-1:0] lb_dout,
	output logic lb_vld
);

// Wait states for ports 0 to 3
localparam int WAIT_LUT [4] = '{1, 3, 0, 6};

// Flat LMMI vectors, one slice per port
wire [P_PORTS-1:0] lmmi_req;
wire [P_PORTS-1:0] lmmi_dir;
wire [P_PORTS*P_ADR-1:0] lmmi_adr;
wire [P_PORTS*P_DAT-1:0] lmmi_wdat;
wire [P_PORTS*P_DAT-1:0] lmmi_rdat;
wire [P_PORTS-1:0] lmmi_vld;
wire [P_PORTS-1:0] lmmi_rdy;

// Bridge
lmmi_bridge
#(
	.P_PORTS (P_PORTS),
	.P_ADR (P_ADR),
	.P_DAT (P_DAT)
)
bridge_inst
(
	.CLK_IN (CLK_IN),
	.RST_IN (RST_IN),
	.lb_adr (lb_adr),
	.lb_wr (lb_wr),
	.lb_rd (lb_rd),
	.lb_din (lb_din),
	.lb_dout (lb_dout),
	.lb_vld (lb_vld),
	.lmmi_req (lmmi_req),
	.lmmi_dir (lmmi_dir),
	.lmmi_adr (lmmi_adr),
	.lmmi_wdat (lmmi_wdat),
	.lmmi_rdat (lmmi_rdat),
	.lmmi_vld (lmmi_vld),
	.lmmi_rdy (lmmi_rdy)
);

// One target per port
for (genvar i = 0; i < P_PORTS; i++)
begin : g_port
	lmmi_target
	#(
		.P_ADR (P_ADR),
		.P_DAT (P_DAT),
		.P_WAIT (WAIT_LUT[i % 4])
	)
	target_inst
	(
		.CLK_IN (CLK_IN),
		.RST_IN (RST_IN),
		.req (lmmi_req[i]),
		.dir (lmmi_dir[i]),
		.adr (lmmi_adr[i*P_ADR +: P_ADR]),
		.wdat (lmmi_wdat[i*P_DAT +: P_DAT]),
		.rdat (lmmi_rdat[i*P_DAT +: P_DAT]),
		.vld (lmmi_vld[i]),
		.rdy (lmmi_rdy[i])
	);
end

endmodule

`default_nettype wire

//--- test/lmmi_subsys_tests.svh
/*
	Directed tests, included inside the testbench module
	Each task starts and ends on a falling clock edge
	Reads only touch scoreboard entries that were written before
*/

`ifndef LMMI_SUBSYS_TESTS_SVH
`define LMMI_SUBSYS_TESTS_SVH

// Full LMMI write with the scoreboard updated once busy clears
task automatic lmmi_write(input int port, input logic [P_ADR-1:0] adr,
	input logic [P_DAT-1:0] dat);
	write_reg(lmmi_pkg::REG_LMMI, sel_word(port, adr, dat));
	write_reg(lmmi_pkg::REG_CTL, 32'(1) << lmmi_pkg::CTL_WR);
	wait_idle(1'b0);
	sb_dat[port][adr] = dat;
	sb_vld[port][adr] = 1'b1;
endtask

// LMMI read and check against the scoreboard
task automatic check_read(input int port, input logic [P_ADR-1:0] adr);
	logic [DAT_W-1:0] word;
	// Clear a stale rdy first
	write_reg(lmmi_pkg::REG_STA, 32'(1) << lmmi_pkg::STA_RDY);
	write_reg(lmmi_pkg::REG_LMMI, sel_word(port, adr, '0));
	write_reg(lmmi_pkg::REG_CTL, 32'(1) << lmmi_pkg::CTL_RD);
	wait_idle(1'b1);
	read_reg(lmmi_pkg::REG_LMMI, word);
	// Bits above the byte read as zero
	cmp_word("lb_dout upper bits", word >> P_DAT, '0);
	cmp_data($sformatf("port %0d read data", port), word[P_DAT-1:0], sb_dat[port][adr]);
endtask

// 1. Idle state after reset
task automatic test_reset();
	logic [DAT_W-1:0] word;
	cmp_bit("lb_vld", lb_vld, 1'b0);
	read_reg(lmmi_pkg::REG_CTL, word);
	cmp_word("ctl", word, '0);
	read_reg(lmmi_pkg::REG_STA, word);
	cmp_word("sta", word, '0);
	read_reg(lmmi_pkg::REG_LMMI, word);
	cmp_word("captured data", word, '0);
	// Valid lasts a single cycle
	@(negedge CLK_IN);
	cmp_bit("lb_vld", lb_vld, 1'b0);
endtask

// 2. Write then read back on every port
task automatic test_each_port();
	logic [P_ADR-1:0] adr;
	logic [DAT_W-1:0] sta;
	for (int p = 0; p < P_PORTS; p++)
	begin
		adr = P_ADR'(rand_bits(P_ADR));
		lmmi_write(p, adr, P_DAT'(rand_bits(P_DAT)));
		check_read(p, adr);
		// rdy stays up and busy is gone
		read_reg(lmmi_pkg::REG_STA, sta);
		cmp_word("sta", sta, 32'(1) << lmmi_pkg::STA_RDY);
	end
endtask

// 3. Same address with a different byte per port
task automatic test_isolation();
	logic [P_ADR-1:0] adr;
	logic [P_DAT-1:0] base;
	adr = P_ADR'(rand_bits(P_ADR));
	base = P_DAT'(rand_bits(P_DAT));
	for (int p = 0; p < P_PORTS; p++)
		lmmi_write(p, adr, base ^ P_DAT'(p));
	for (int p = 0; p < P_PORTS; p++)
		check_read(p, adr);
endtask

// 4. Write-1-to-clear on rdy
task automatic test_rdy_clear();
	logic [DAT_W-1:0] sta;
	lmmi_write(1, 9'h155, 8'hc3);
	check_read(1, 9'h155);
	write_reg(lmmi_pkg::REG_STA, '0);
	read_reg(lmmi_pkg::REG_STA, sta);
	cmp_word("sta after writing 0", sta, 32'(1) << lmmi_pkg::STA_RDY);
	write_reg(lmmi_pkg::REG_STA, 32'(1) << lmmi_pkg::STA_RDY);
	read_reg(lmmi_pkg::REG_STA, sta);
	cmp_word("sta after writing 1", sta, '0);
endtask

// 5. Slow port 3 shows busy and fast port 2 finishes quickly
task automatic test_backpressure();
	logic [P_ADR-1:0] adr;
	logic [P_DAT-1:0] dat;
	logic [DAT_W-1:0] sta;
	adr = P_ADR'(rand_bits(P_ADR));
	dat = P_DAT'(rand_bits(P_DAT));
	write_reg(lmmi_pkg::REG_LMMI, sel_word(3, adr, dat));
	write_reg(lmmi_pkg::REG_CTL, 32'(1) << lmmi_pkg::CTL_WR);
	// Immediate poll and the next few while port 3 still waits
	repeat (4)
	begin
		read_reg(lmmi_pkg::REG_STA, sta);
		cmp_bit("busy", sta[lmmi_pkg::STA_BUSY], 1'b1);
	end
	wait_idle(1'b0);
	sb_dat[3][adr] = dat;
	sb_vld[3][adr] = 1'b1;
	check_read(3, adr);
	// Poll limit in wait_idle bounds the fast port
	adr = P_ADR'(rand_bits(P_ADR));
	lmmi_write(2, adr, P_DAT'(rand_bits(P_DAT)));
	check_read(2, adr);
endtask

// 6. Thirty random operations on a small address window
task automatic test_random_mix();
	int p;
	logic [P_ADR-1:0] adr;
	logic do_rd;
	repeat (30)
	begin
		p = int'(rand_bits(PORT_W));
		adr = P_ADR'(rand_bits(4));
		do_rd = 1'(rand_bits(1));
		if (do_rd && sb_vld[p][adr])
			check_read(p, adr);
		else
			lmmi_write(p, adr, P_DAT'(rand_bits(P_DAT)));
	end
endtask

`endif

//--- test/lmmi_subsys_tb.sv
/*
	Directed testbench for the LMMI bridge subsystem
	Local bus is driven on the falling edge and sampled one falling edge later
	Runs stop at the first mismatch
	Scoreboard holds the written LMMI bytes per port, unwritten entries are never read
	Test tasks come from the included header
*/

`default_nettype none

module lmmi_subsys_tb;

timeunit 1ns;
timeprecision 100ps;

// Must match the subsystem parameter set
localparam int P_PORTS = 4;
localparam int P_ADR = 9;
localparam int P_DAT = 8;
localparam int PORT_W = $clog2(P_PORTS);
localparam int DEPTH = 2 ** P_ADR;
localparam int ADR_W = lmmi_pkg::LB_ADR_W;
localparam int DAT_W = lmmi_pkg::LB_DAT_W;

// Status polls before a transfer counts as stuck
localparam int POLL_MAX = 40;

// Whole run limit in clock cycles
localparam int CYCLE_MAX = 20000;

logic CLK_IN;
logic RST_IN;
logic [ADR_W-1:0] lb_adr;
logic lb_wr;
logic lb_rd;
logic [DAT_W-1:0] lb_din;
wire [DAT_W-1:0] lb_dout;
wire lb_vld;

// Scoreboard per port
logic [P_DAT-1:0] sb_dat [P_PORTS][DEPTH];
bit sb_vld [P_PORTS][DEPTH];

logic [31:0] lfsr;
int cycles = 0;

lmmi_subsys
#(
	.P_PORTS (P_PORTS),
	.P_ADR (P_ADR),
	.P_DAT (P_DAT)
)
UUT
(
	.CLK_IN (CLK_IN),
	.RST_IN (RST_IN),
	.lb_adr (lb_adr),
	.lb_wr (lb_wr),
	.lb_rd (lb_rd),
	.lb_din (lb_din),
	.lb_dout (lb_dout),
	.lb_vld (lb_vld)
);

// 8 ns clock
initial
begin
	CLK_IN = 1'b0;
	forever #4 CLK_IN = ~CLK_IN;
end

// Print the reason, then the fail line, then stop
task automatic abort_run(input string why);
	$display("%s", why);
	$display("=== FAIL ===");
	$fatal(1);
endtask

// Run limit
always @(posedge CLK_IN)
begin
	cycles <= cycles + 1;
	if (cycles >= CYCLE_MAX)
		abort_run("Timeout, the tests did not finish within the cycle limit");
end

// Galois LFSR step, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ 32'h8020_0003;
	return s >> 1;
endfunction

// One step per bit taken, first bit ends up as MSB
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		lfsr = lfsr_next(lfsr);
		v = {v[30:0], lfsr[0]};
	end
	return v;
endfunction

// Selector word, port at bit 0, then address, then data
function automatic logic [DAT_W-1:0] sel_word(input int port, input logic [P_ADR-1:0] adr,
	input logic [P_DAT-1:0] dat);
	logic [DAT_W-1:0] w;
	w = '0;
	w[PORT_W-1:0] = PORT_W'(port);
	w[PORT_W +: P_ADR] = adr;
	w[PORT_W + P_ADR +: P_DAT] = dat;
	return w;
endfunction

// Local-bus word compare
task automatic cmp_word(input string name, input logic [DAT_W-1:0] got,
	input logic [DAT_W-1:0] exp);
	if (got !== exp)
		abort_run($sformatf("Error %s got 0x%h expected 0x%h", name, got, exp));
endtask

// LMMI byte compare
task automatic cmp_data(input string name, input logic [P_DAT-1:0] got,
	input logic [P_DAT-1:0] exp);
	if (got !== exp)
		abort_run($sformatf("Error %s got 0x%h expected 0x%h", name, got, exp));
endtask

// Single-bit flag compare
task automatic cmp_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
		abort_run($sformatf("Error %s got 0x%h expected 0x%h", name, got, exp));
endtask

// Caller sits on a falling edge, one strobe cycle
task automatic write_reg(input int adr, input logic [DAT_W-1:0] dat);
	lb_adr = ADR_W'(adr);
	lb_din = dat;
	lb_wr = 1'b1;
	@(negedge CLK_IN);
	lb_wr = 1'b0;
endtask

// Response cycle is the one after the strobe
task automatic read_reg(input int adr, output logic [DAT_W-1:0] dat);
	lb_adr = ADR_W'(adr);
	lb_rd = 1'b1;
	@(negedge CLK_IN);
	cmp_bit("lb_vld", lb_vld, 1'b1);
	dat = lb_dout;
	lb_rd = 1'b0;
endtask

// Poll status until busy clears, and rdy is set when asked for
task automatic wait_idle(input bit want_rdy);
	logic [DAT_W-1:0] sta;
	int polls;
	polls = 1;
	read_reg(lmmi_pkg::REG_STA, sta);
	while (sta[lmmi_pkg::STA_BUSY] || (want_rdy && !sta[lmmi_pkg::STA_RDY]))
	begin
		if (polls >= POLL_MAX)
			abort_run("Status poll limit reached, the LMMI transfer never finished");
		read_reg(lmmi_pkg::REG_STA, sta);
		polls++;
	end
endtask

`include "lmmi_subsys_tests.svh"

initial
begin
	RST_IN = 1'b1;
	lb_adr = '0;
	lb_wr = 1'b0;
	lb_rd = 1'b0;
	lb_din = '0;
	lfsr = 32'h9d73;
	repeat (4) @(posedge CLK_IN);
	@(negedge CLK_IN);
	RST_IN = 1'b0;
	@(negedge CLK_IN);

	test_reset();
	test_each_port();
	test_isolation();
	test_rdy_clear();
	test_backpressure();
	test_random_mix();

	$display("=== PASS ===");
	$finish;
end

endmodule

`default_nettype wire

//--- src.f
+incdir+test
source/lmmi_pkg.sv
source/lmmi_target.sv
source/lmmi_bridge.sv
source/lmmi_subsys.sv
test/lmmi_subsys_tb.sv
